/* hdl/sd_pkg.sv */
`default_nettype none

package sd_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [9:0] byte_idx_t;
  typedef logic [31:0] block_addr_t;

  localparam int block_bytes = 512;
  localparam block_addr_t start_block = 32'h0010_0000;

  // big-endian marker at the head of every test block
  localparam int sig_bytes = 4;
  typedef logic [sig_bytes*8-1:0] sig_t;
  localparam sig_t signature = 32'hAABB_CCDD;

  // unused bytes of the result block
  localparam byte_t fill_byte = 8'hFF;

endpackage

`default_nettype wire

/* hdl/uut_pkg.sv */
`default_nettype none

package uut_pkg;

  localparam int operand1_w = 32;
  localparam int operand2_w = 32;
  localparam int result_w = 32;

  typedef logic [operand1_w-1:0] operand1_t;
  typedef logic [operand2_w-1:0] operand2_t;
  typedef logic [result_w-1:0] result_t;
  typedef logic [63:0] cycle_count_t;

  localparam cycle_count_t default_timeout = 64'h1000_0000;

  // read block, fields follow the signature
  localparam int op1_offset = 4;
  localparam int op2_offset = op1_offset + operand1_w / 8;
  localparam int exp_offset = op2_offset + operand2_w / 8;

  // result block
  localparam int cycles_offset = result_w / 8;
  localparam int status_offset = cycles_offset + 8;

endpackage

`default_nettype wire

/* hdl/field_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module field_capture #(
  parameter int width_bytes = 4,
  parameter bit msb_first = 1'b0
) (
  input  wire logic                     clk,
  input  wire logic                     rst,
  input  wire logic                     clear_i,
  input  wire logic                     we_i,
  input  wire logic [width_bytes-1:0]   byte_sel_i,
  input  wire sd_pkg::byte_t            data_i,
  output logic [width_bytes*8-1:0]      field_o
);
  import sd_pkg::*;

  // stream byte k lands in lane k, mirrored for big-endian fields
  always_ff @(posedge clk) begin
    if (rst || clear_i) begin
      field_o <= '0;
    end else if (we_i) begin
      for (int k = 0; k < width_bytes; k++) begin
        if (byte_sel_i[k]) begin
          field_o[(msb_first ? width_bytes - 1 - k : k)*$bits(byte_t) +: $bits(byte_t)]
            <= data_i;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/block_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module block_decoder (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              clear_i,
  input  wire logic              byte_valid_i,
  input  wire sd_pkg::byte_idx_t byte_idx_i,
  input  wire sd_pkg::byte_t     data_i,
  output uut_pkg::operand1_t     op1_o,
  output uut_pkg::operand2_t     op2_o,
  output uut_pkg::result_t       expected_o,
  output logic                   sig_ok_o
);
  import sd_pkg::*;
  import uut_pkg::*;

  logic [sig_bytes-1:0]    sig_sel;
  logic [operand1_w/8-1:0] op1_sel;
  logic [operand2_w/8-1:0] op2_sel;
  logic [result_w/8-1:0]   exp_sel;
  sig_t                    sig_q;

  // one lane select per field byte, taken from the layout offsets
  always_comb begin
    for (int k = 0; k < sig_bytes; k++) begin
      sig_sel[k] = (int'(byte_idx_i) == k);
    end
    for (int k = 0; k < operand1_w / 8; k++) begin
      op1_sel[k] = (int'(byte_idx_i) == op1_offset + k);
    end
    for (int k = 0; k < operand2_w / 8; k++) begin
      op2_sel[k] = (int'(byte_idx_i) == op2_offset + k);
    end
    for (int k = 0; k < result_w / 8; k++) begin
      exp_sel[k] = (int'(byte_idx_i) == exp_offset + k);
    end
  end

  field_capture #(.width_bytes(sig_bytes), .msb_first(1'b1)) i_sig (
    .clk(clk), .rst(rst), .clear_i(clear_i), .we_i(byte_valid_i),
    .byte_sel_i(sig_sel), .data_i(data_i), .field_o(sig_q)
  );

  field_capture #(.width_bytes(operand1_w / 8), .msb_first(1'b0)) i_op1 (
    .clk(clk), .rst(rst), .clear_i(clear_i), .we_i(byte_valid_i),
    .byte_sel_i(op1_sel), .data_i(data_i), .field_o(op1_o)
  );

  field_capture #(.width_bytes(operand2_w / 8), .msb_first(1'b0)) i_op2 (
    .clk(clk), .rst(rst), .clear_i(clear_i), .we_i(byte_valid_i),
    .byte_sel_i(op2_sel), .data_i(data_i), .field_o(op2_o)
  );

  field_capture #(.width_bytes(result_w / 8), .msb_first(1'b0)) i_exp (
    .clk(clk), .rst(rst), .clear_i(clear_i), .we_i(byte_valid_i),
    .byte_sel_i(exp_sel), .data_i(data_i), .field_o(expected_o)
  );

  assign sig_ok_o = (sig_q == signature);

endmodule

`default_nettype wire

/* hdl/test_runner.sv */
`timescale 1ns/1ps
`default_nettype none

module test_runner #(
  parameter uut_pkg::cycle_count_t timeout_cycles = uut_pkg::default_timeout
) (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic             start_i,
  input  wire logic             end_uut_i,
  input  wire logic             err_uut_i,
  input  wire uut_pkg::result_t uut_result_i,
  output logic                  rst_uut_o,
  output logic                  done_o,
  output uut_pkg::cycle_count_t cycles_o,
  output uut_pkg::result_t      result_o,
  output logic                  err_o,
  output logic                  timeout_o
);
  import uut_pkg::*;

  logic         running;
  logic         finish;
  cycle_count_t count;

  assign finish = running && (end_uut_i || err_uut_i || count == timeout_cycles);

  always_ff @(posedge clk) begin
    if (rst) begin
      running   <= 1'b0;
      rst_uut_o <= 1'b1;
      done_o    <= 1'b0;
      err_o     <= 1'b0;
      timeout_o <= 1'b0;
      count     <= '0;
    end else begin
      done_o <= finish;
      if (start_i) begin
        running   <= 1'b1;
        rst_uut_o <= 1'b0;
        count     <= '0;
      end else if (finish) begin
        running   <= 1'b0;
        rst_uut_o <= 1'b1;
        err_o     <= err_uut_i;
        // end or error win over a timeout in the same cycle
        timeout_o <= !(end_uut_i || err_uut_i);
      end else if (running) begin
        count <= count + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (finish) begin
      result_o <= uut_result_i;
      cycles_o <= count;
    end
  end

endmodule

`default_nettype wire

/* hdl/result_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module result_writer (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  compare_i,
  input  wire sd_pkg::byte_idx_t     byte_idx_i,
  input  wire uut_pkg::result_t      result_i,
  input  wire uut_pkg::result_t      expected_i,
  input  wire uut_pkg::cycle_count_t cycles_i,
  input  wire logic                  uut_err_i,
  input  wire logic                  timeout_i,
  output sd_pkg::byte_t              wr_byte_o,
  output logic [31:0]                error_count_o
);
  import sd_pkg::*;
  import uut_pkg::*;

  logic  mismatch;
  byte_t status_q;
  int    idx;

  assign mismatch = (result_i != expected_i);
  assign idx = int'(byte_idx_i);

  // status: bit 0 mismatch, bit 1 uut error, bit 2 timeout
  always_ff @(posedge clk) begin
    if (rst) begin
      status_q      <= '0;
      error_count_o <= '0;
    end else if (compare_i) begin
      status_q <= {5'b0, timeout_i, uut_err_i, mismatch};
      if (mismatch || uut_err_i) begin
        error_count_o <= error_count_o + 32'd1;
      end
    end
  end

  // result block, little-endian fields then fill
  always_comb begin
    if (idx < cycles_offset) begin
      wr_byte_o = result_i[idx*8 +: 8];
    end else if (idx < status_offset) begin
      wr_byte_o = cycles_i[(idx - cycles_offset)*8 +: 8];
    end else if (idx == status_offset) begin
      wr_byte_o = status_q;
    end else begin
      wr_byte_o = fill_byte;
    end
  end

endmodule

`default_nettype wire

/* hdl/sd_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_sequencer (
  input  wire logic          clk,
  input  wire logic          rst,
  input  wire logic          spi_busy_i,
  output logic               spi_rst_o,
  output logic               spi_r_block_o,
  output logic               spi_r_byte_o,
  output logic               spi_w_block_o,
  output logic               spi_w_byte_o,
  output sd_pkg::byte_t      spi_data_in_o,
  output sd_pkg::block_addr_t spi_block_addr_o,
  input  wire sd_pkg::byte_t wr_byte_i,
  output logic               byte_valid_o,
  output sd_pkg::byte_idx_t  byte_idx_o,
  output logic               clear_o,
  output logic               run_start_o,
  input  wire logic          run_done_i,
  output logic               compare_o,
  input  wire logic          sig_ok_i,
  output logic               done_o
);
  import sd_pkg::*;

  typedef enum logic [4:0] {
    s_rst_host, s_rst_wait, s_idle,
    s_rd_block, s_rd_block_wait, s_rd_byte, s_rd_byte_wait,
    s_check, s_run, s_compare,
    s_wr_block, s_wr_block_wait, s_wr_load, s_wr_byte, s_wr_byte_wait,
    s_next, s_stop
  } state_t;

  state_t state;
  state_t next_state;
  logic   last_byte;
  logic   byte_step;

  assign last_byte = (byte_idx_o == byte_idx_t'(block_bytes - 1));

  always_comb begin
    next_state    = state;
    spi_rst_o     = 1'b0;
    spi_r_block_o = 1'b0;
    spi_r_byte_o  = 1'b0;
    spi_w_block_o = 1'b0;
    spi_w_byte_o  = 1'b0;
    byte_valid_o  = 1'b0;
    byte_step     = 1'b0;
    clear_o       = 1'b0;
    run_start_o   = 1'b0;
    compare_o     = 1'b0;
    done_o        = 1'b0;
    case (state)
      s_rst_host: begin
        spi_rst_o = 1'b1;
        if (spi_busy_i) next_state = s_rst_wait;
      end
      s_rst_wait: if (!spi_busy_i) next_state = s_idle;
      s_idle: begin
        clear_o = 1'b1;
        if (!spi_busy_i) next_state = s_rd_block;
      end
      s_rd_block: begin
        spi_r_block_o = 1'b1;
        if (spi_busy_i) next_state = s_rd_block_wait;
      end
      s_rd_block_wait: begin
        spi_r_block_o = 1'b1;
        if (!spi_busy_i) next_state = s_rd_byte;
      end
      s_rd_byte: begin
        spi_r_block_o = 1'b1;
        spi_r_byte_o  = 1'b1;
        if (spi_busy_i) next_state = s_rd_byte_wait;
      end
      s_rd_byte_wait: begin
        spi_r_block_o = 1'b1;
        // busy falling, data_out holds the byte this cycle
        if (!spi_busy_i) begin
          byte_valid_o = 1'b1;
          byte_step    = !last_byte;
          next_state   = last_byte ? s_check : s_rd_byte;
        end
      end
      s_check: begin
        run_start_o = sig_ok_i;
        next_state  = sig_ok_i ? s_run : s_stop;
      end
      s_run: if (run_done_i) next_state = s_compare;
      s_compare: begin
        compare_o  = 1'b1;
        next_state = s_wr_block;
      end
      s_wr_block: begin
        spi_w_block_o = 1'b1;
        if (spi_busy_i) next_state = s_wr_block_wait;
      end
      s_wr_block_wait: begin
        spi_w_block_o = 1'b1;
        if (!spi_busy_i) next_state = s_wr_load;
      end
      s_wr_load: begin
        spi_w_block_o = 1'b1;
        next_state    = s_wr_byte;
      end
      s_wr_byte: begin
        spi_w_block_o = 1'b1;
        spi_w_byte_o  = 1'b1;
        if (spi_busy_i) next_state = s_wr_byte_wait;
      end
      s_wr_byte_wait: begin
        spi_w_block_o = 1'b1;
        if (!spi_busy_i) begin
          byte_step  = !last_byte;
          next_state = last_byte ? s_next : s_wr_load;
        end
      end
      s_next: next_state = s_idle;
      s_stop: done_o = 1'b1;
      default: next_state = s_rst_host;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state            <= s_rst_host;
      byte_idx_o       <= '0;
      spi_block_addr_o <= start_block;
    end else begin
      state <= next_state;
      if (state == s_idle || state == s_compare) begin
        byte_idx_o <= '0;
      end else if (byte_step) begin
        byte_idx_o <= byte_idx_o + 1'b1;
      end
      if (state == s_next) begin
        spi_block_addr_o <= spi_block_addr_o + 1'b1;
      end
    end
  end

  // held from the byte strobe until busy falls
  always_ff @(posedge clk) begin
    if (state == s_wr_load) begin
      spi_data_in_o <= wr_byte_i;
    end
  end

endmodule

`default_nettype wire

/* hdl/autotest_top.sv */
`timescale 1ns/1ps
`default_nettype none

module autotest_top #(
  parameter uut_pkg::cycle_count_t timeout_cycles = uut_pkg::default_timeout
) (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               spi_busy_i,
  input  wire sd_pkg::byte_t      spi_data_out_i,
  output sd_pkg::block_addr_t     spi_block_addr_o,
  output logic                    spi_r_block_o,
  output logic                    spi_r_byte_o,
  output logic                    spi_rst_o,
  output sd_pkg::byte_t           spi_data_in_o,
  output logic                    spi_w_block_o,
  output logic                    spi_w_byte_o,
  output logic                    rst_uut_o,
  input  wire logic               end_uut_i,
  input  wire logic               err_uut_i,
  output uut_pkg::operand1_t      input_1_o,
  output uut_pkg::operand2_t      input_2_o,
  input  wire uut_pkg::result_t   output_uut_i,
  output logic [31:0]             error_count_o,
  output logic                    done_o
);
  import sd_pkg::*;
  import uut_pkg::*;

  logic         byte_valid;
  byte_idx_t    byte_idx;
  logic         clear;
  logic         sig_ok;
  logic         run_start;
  logic         run_done;
  logic         compare_stb;
  byte_t        wr_byte;
  result_t      expected;
  result_t      run_result;
  cycle_count_t run_cycles;
  logic         run_err;
  logic         run_timeout;

  sd_sequencer i_sequencer (
    .clk(clk), .rst(rst), .spi_busy_i(spi_busy_i),
    .spi_rst_o(spi_rst_o), .spi_r_block_o(spi_r_block_o), .spi_r_byte_o(spi_r_byte_o),
    .spi_w_block_o(spi_w_block_o), .spi_w_byte_o(spi_w_byte_o),
    .spi_data_in_o(spi_data_in_o), .spi_block_addr_o(spi_block_addr_o),
    .wr_byte_i(wr_byte), .byte_valid_o(byte_valid), .byte_idx_o(byte_idx),
    .clear_o(clear), .run_start_o(run_start), .run_done_i(run_done),
    .compare_o(compare_stb), .sig_ok_i(sig_ok), .done_o(done_o)
  );

  block_decoder i_decoder (
    .clk(clk), .rst(rst), .clear_i(clear), .byte_valid_i(byte_valid),
    .byte_idx_i(byte_idx), .data_i(spi_data_out_i),
    .op1_o(input_1_o), .op2_o(input_2_o), .expected_o(expected), .sig_ok_o(sig_ok)
  );

  test_runner #(.timeout_cycles(timeout_cycles)) i_runner (
    .clk(clk), .rst(rst), .start_i(run_start),
    .end_uut_i(end_uut_i), .err_uut_i(err_uut_i), .uut_result_i(output_uut_i),
    .rst_uut_o(rst_uut_o), .done_o(run_done), .cycles_o(run_cycles),
    .result_o(run_result), .err_o(run_err), .timeout_o(run_timeout)
  );

  result_writer i_writer (
    .clk(clk), .rst(rst), .compare_i(compare_stb), .byte_idx_i(byte_idx),
    .result_i(run_result), .expected_i(expected), .cycles_i(run_cycles),
    .uut_err_i(run_err), .timeout_i(run_timeout),
    .wr_byte_o(wr_byte), .error_count_o(error_count_o)
  );

endmodule

`default_nettype wire

/* tests/tb_autotest.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_autotest;

  localparam logic [31:0] start_block = 32'h0010_0000;
  localparam logic [31:0] good_sig = 32'hAABB_CCDD;
  localparam int n_blocks = 6;
  localparam int tb_timeout = 300;
  localparam int done_limit = 200000;
  localparam int quiet_cycles = 50;

  logic        clk = 1'b0;
  logic        rst;
  logic        spi_busy;
  logic [7:0]  spi_data_out;
  logic [31:0] spi_block_addr;
  logic        spi_r_block;
  logic        spi_r_byte;
  logic        spi_rst;
  logic [7:0]  spi_data_in;
  logic        spi_w_block;
  logic        spi_w_byte;
  logic        rst_uut;
  logic        end_uut;
  logic        err_uut;
  logic [31:0] input_1;
  logic [31:0] input_2;
  logic [31:0] output_uut;
  logic [31:0] error_count;
  logic        done;

  // card contents and per-block test parameters
  logic [7:0]  card [0:n_blocks*512-1];
  logic [31:0] sig_v [0:n_blocks-1];
  logic [31:0] op1_v [0:n_blocks-1];
  logic [31:0] op2_v [0:n_blocks-1];
  logic [31:0] exp_v [0:n_blocks-1];
  int          delay_v [0:n_blocks-1];
  logic        err_v [0:n_blocks-1];
  logic [63:0] run_cycles [0:n_blocks-1];

  logic [7:0]  wr_buf [0:511];
  logic [31:0] lfsr;
  logic [31:0] next_rd_addr;
  logic [31:0] rd_addr;
  logic [31:0] wr_addr;
  logic        in_read;
  logic        in_write;
  logic        blk_done;
  logic        uut_active;
  int          rd_blk;
  int          rd_idx;
  int          wr_idx;
  int          done_blk;
  int          run_blk;
  int          uut_count;
  int          exp_errs;
  int          blocks_checked;

  always #5 clk = ~clk;

  autotest_top #(.timeout_cycles(64'd300)) i_dut (
    .clk(clk), .rst(rst), .spi_busy_i(spi_busy), .spi_data_out_i(spi_data_out),
    .spi_block_addr_o(spi_block_addr), .spi_r_block_o(spi_r_block),
    .spi_r_byte_o(spi_r_byte), .spi_rst_o(spi_rst), .spi_data_in_o(spi_data_in),
    .spi_w_block_o(spi_w_block), .spi_w_byte_o(spi_w_byte), .rst_uut_o(rst_uut),
    .end_uut_i(end_uut), .err_uut_i(err_uut), .input_1_o(input_1), .input_2_o(input_2),
    .output_uut_i(output_uut), .error_count_o(error_count), .done_o(done)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      fail_run($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected));
    end
  endtask

  // fibonacci taps at bits 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      val = {val[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [63:0] expected_cycles(input int b);
    return (delay_v[b] > tb_timeout) ? 64'(tb_timeout) : 64'(delay_v[b]);
  endfunction

  // expected result block with the sum, cycle count, status and fill
  function automatic logic [4095:0] ref_block(input int b, input logic [63:0] cycles);
    logic [4095:0] blk;
    logic [31:0]   sum;
    logic          timed_out;
    sum = op1_v[b] + op2_v[b];
    timed_out = delay_v[b] > tb_timeout;
    blk = {512{8'hFF}};
    for (int k = 0; k < 4; k++) begin
      blk[k*8 +: 8] = sum[k*8 +: 8];
    end
    for (int k = 0; k < 8; k++) begin
      blk[(4 + k)*8 +: 8] = cycles[k*8 +: 8];
    end
    blk[12*8 +: 8] = {5'b0, timed_out, err_v[b] && !timed_out, sum != exp_v[b]};
    return blk;
  endfunction

  task automatic build_card;
    logic [31:0] r;
    for (int b = 0; b < n_blocks; b++) begin
      for (int i = 0; i < 512; i++) begin
        draw_bits(8, r);
        card[b*512 + i] = r[7:0];
      end
      for (int k = 0; k < 4; k++) begin
        card[b*512 + k] = sig_v[b][31 - k*8 -: 8];
        card[b*512 + 4 + k] = op1_v[b][k*8 +: 8];
        card[b*512 + 8 + k] = op2_v[b][k*8 +: 8];
        card[b*512 + 12 + k] = exp_v[b][k*8 +: 8];
      end
    end
  endtask

  // random length busy pulse with the data valid as busy falls
  task automatic answer_strobe(input logic with_data, input logic [7:0] data);
    logic [31:0] pre;
    logic [31:0] len;
    draw_bits(1, pre);
    draw_bits(2, len);
    repeat (pre) begin
      @(posedge clk);
      #1;
    end
    spi_busy = 1'b1;
    repeat (len + 1) begin
      @(posedge clk);
      #1;
    end
    if (with_data) spi_data_out = data;
    spi_busy = 1'b0;
  endtask

  // sd host and card model
  initial begin
    @(negedge rst);
    forever begin
      @(posedge clk);
      #1;
      blk_done = 1'b0;
      if (spi_rst) begin
        answer_strobe(1'b0, 8'h00);
      end else if (!in_read && spi_r_block) begin
        check_value("spi_block_addr_o", spi_block_addr, next_rd_addr);
        rd_addr = spi_block_addr;
        rd_blk = int'(spi_block_addr - start_block);
        if (rd_blk >= n_blocks) fail_run("read from a block the card does not hold");
        rd_idx = 0;
        in_read = 1'b1;
        answer_strobe(1'b0, 8'h00);
      end else if (in_read && spi_r_byte) begin
        if (rd_idx >= 512) fail_run("more than 512 bytes read from one block");
        answer_strobe(1'b1, card[rd_blk*512 + rd_idx]);
        rd_idx++;
      end else if (in_read && !spi_r_block) begin
        in_read = 1'b0;
        if (rd_idx != 512) fail_run("block read ended before 512 bytes");
      end else if (!in_write && spi_w_block) begin
        check_value("spi_block_addr_o", spi_block_addr, rd_addr);
        wr_addr = spi_block_addr;
        wr_idx = 0;
        in_write = 1'b1;
        answer_strobe(1'b0, 8'h00);
      end else if (in_write && spi_w_byte) begin
        if (wr_idx >= 512) fail_run("more than 512 bytes written to one block");
        wr_buf[wr_idx] = spi_data_in;
        wr_idx++;
        answer_strobe(1'b0, 8'h00);
      end else if (in_write && !spi_w_block) begin
        in_write = 1'b0;
        if (wr_idx != 512) fail_run("block write ended before 512 bytes");
        next_rd_addr = wr_addr + 1;
        done_blk = rd_blk;
        blk_done = 1'b1;
      end
    end
  end

  // uut model adds the operands and finishes after the block's delay
  initial begin
    @(negedge rst);
    forever begin
      @(posedge clk);
      #1;
      if (!uut_active && !rst_uut) begin
        uut_active = 1'b1;
        run_blk = rd_blk;
        uut_count = 0;
        check_value("input_1_o", input_1, op1_v[run_blk]);
        check_value("input_2_o", input_2, op2_v[run_blk]);
        output_uut = input_1 + input_2;
      end else if (uut_active && rst_uut) begin
        uut_active = 1'b0;
        run_cycles[run_blk] = 64'(uut_count);
        end_uut = 1'b0;
        err_uut = 1'b0;
      end else if (uut_active && !end_uut && !err_uut) begin
        uut_count++;
        if (uut_count == delay_v[run_blk]) begin
          if (err_v[run_blk]) err_uut = 1'b1;
          else end_uut = 1'b1;
        end
      end
    end
  end

  always @(posedge clk) begin : compare_written
    logic [4095:0] exp_blk;
    if (blk_done) begin
      check_value("uut cycle count", run_cycles[done_blk], expected_cycles(done_blk));
      exp_blk = ref_block(done_blk, run_cycles[done_blk]);
      for (int i = 0; i < 512; i++) begin
        check_value($sformatf("spi_data_in_o[%0d]", i), wr_buf[i], exp_blk[i*8 +: 8]);
      end
      // only a mismatch or a uut error counts
      if (exp_blk[12*8] || exp_blk[12*8 + 1]) exp_errs++;
      check_value("error_count_o", error_count, exp_errs);
      blocks_checked++;
    end
  end

  initial begin : main
    int          waited;
    logic [31:0] r;
    rst = 1'b1;
    spi_busy = 1'b0;
    spi_data_out = 8'h00;
    end_uut = 1'b0;
    err_uut = 1'b0;
    output_uut = '0;
    in_read = 1'b0;
    in_write = 1'b0;
    blk_done = 1'b0;
    uut_active = 1'b0;
    exp_errs = 0;
    blocks_checked = 0;
    next_rd_addr = start_block;
    lfsr = 32'he65c_2ea8;
    for (int b = 0; b < n_blocks; b++) begin
      sig_v[b] = good_sig;
      draw_bits(32, r);
      op1_v[b] = r;
      draw_bits(32, r);
      op2_v[b] = r;
      exp_v[b] = op1_v[b] + op2_v[b];
      err_v[b] = 1'b0;
      run_cycles[b] = '0;
    end
    op1_v[0] = 32'h1234_5678;
    op2_v[0] = 32'h0101_0101;
    exp_v[0] = op1_v[0] + op2_v[0];
    delay_v[0] = 5;
    op1_v[1] = 32'hDEAD_0000;
    op2_v[1] = 32'h0000_BEEF;
    exp_v[1] = (op1_v[1] + op2_v[1]) ^ 32'h0000_0100;
    delay_v[1] = 17;
    delay_v[2] = 9;
    err_v[2] = 1'b1;
    delay_v[3] = 1000;
    delay_v[4] = 40;
    delay_v[5] = 1;
    sig_v[5] = 32'hAABB_CCDE;
    build_card();

    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    check_value("spi_rst_o", spi_rst, 1'b1);
    check_value("rst_uut_o", rst_uut, 1'b1);
    check_value("spi_r_block_o", spi_r_block, 1'b0);
    check_value("spi_r_byte_o", spi_r_byte, 1'b0);
    check_value("spi_w_block_o", spi_w_block, 1'b0);
    check_value("spi_w_byte_o", spi_w_byte, 1'b0);
    check_value("error_count_o", error_count, 0);
    check_value("done_o", done, 1'b0);

    waited = 0;
    while (!done && waited < done_limit) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!done) fail_run("sequencer did not raise done_o in time");
    check_value("result blocks written", blocks_checked, n_blocks - 1);
    check_value("error_count_o", error_count, exp_errs);

    // stopped for good after the bad signature
    for (int c = 0; c < quiet_cycles; c++) begin
      @(posedge clk);
      #1;
      check_value("done_o", done, 1'b1);
      check_value("spi strobes", {spi_rst, spi_r_block, spi_r_byte, spi_w_block, spi_w_byte},
                  5'b0);
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
hdl/sd_pkg.sv
hdl/uut_pkg.sv
hdl/field_capture.sv
hdl/block_decoder.sv
hdl/test_runner.sv
hdl/result_writer.sv
hdl/sd_sequencer.sv
hdl/autotest_top.sv
tests/tb_autotest.sv

/* Bender.yml */
package:
  name: autotest

sources:
  - hdl/sd_pkg.sv
  - hdl/uut_pkg.sv
  - hdl/field_capture.sv
  - hdl/block_decoder.sv
  - hdl/test_runner.sv
  - hdl/result_writer.sv
  - hdl/sd_sequencer.sv
  - hdl/autotest_top.sv
  - target: test
    files:
      - tests/tb_autotest.sv
